/* Makefile */
VERILATOR ?= verilator
TOP ?= tbTop
BUILD_DIR ?= obj_dir
FILE_LIST ?= files.f
LOG ?= sim.log
PASS_MSG ?= sim passed
VFLAGS ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/ctrlPkg.sv */
package ctrlPkg;

	import lc3Pkg::*;

	// Bus driver
	typedef enum logic [2:0] {
		busNone,
		busPc,
		busMdr,
		busAlu,
		busMarmux
	} busSrcT;

	typedef enum logic [1:0] {
		pcInc,
		pcBus,
		pcAdder
	} pcSelT;

	typedef enum logic {
		addr1Pc,
		addr1Base
	} addr1SelT;

	typedef enum logic [1:0] {
		addr2Zero,
		addr2Off6,
		addr2Off9,
		addr2Off11
	} addr2SelT;

	typedef enum logic [1:0] {
		aluAdd,
		aluAnd,
		aluNot,
		aluPass
	} aluOpT;

	// One control word per cycle from the controller
	typedef struct packed {
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldBen;
		logic ldCc;
		logic ldReg;
		logic ldPc;
		logic ldLed;
		busSrcT gate;
		pcSelT pcSel;
		addr1SelT addr1Sel;
		addr2SelT addr2Sel;
		// 0 picks IR[11:9], 1 picks R7
		logic drSel;
		// 0 picks IR[11:9], 1 picks IR[8:6]
		logic sr1Sel;
		// Lets IR[5] pick imm5 over SR2
		logic sr2Imm;
		aluOpT aluOp;
		// MDR takes memory data when set, the bus when clear
		logic mioEn;
	} ctrlWordT;

	typedef struct packed {
		wordT addr;
		wordT wdata;
		logic we;
	} memReqT;

	typedef struct packed {
		wordT rdata;
	} memRspT;

endpackage

/* common/lc3Pkg.sv */
package lc3Pkg;

	// Machine word and register index
	typedef logic [15:0] wordT;
	typedef logic [2:0] regIdxT;

	// Opcodes in IR[15:12]
	// Values that are not listed here halt the core like PAUSE
	typedef enum logic [3:0] {
		opBr    = 4'b0000,
		opAdd   = 4'b0001,
		opLd    = 4'b0010,
		opSt    = 4'b0011,
		opAnd   = 4'b0101,
		opLdr   = 4'b0110,
		opStr   = 4'b0111,
		opNot   = 4'b1001,
		opJmp   = 4'b1100,
		opPause = 4'b1101,
		opLea   = 4'b1110
	} opcodeT;

	// Condition codes
	typedef struct packed {
		logic n;
		logic z;
		logic p;
	} ccT;

	// First instruction address after reset
	localparam wordT resetPc = 16'h3000;

endpackage

/* datapath/datapath.sv */
module datapath
	import lc3Pkg::*, ctrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input ctrlWordT ctrl,
	input wordT memRdata,
	output opcodeT opcode,
	output logic ben,
	output wordT mar,
	output wordT mdr,
	output logic [11:0] led
);

	wordT pc;
	wordT ir;
	ccT cc;
	wordT bus;
	wordT aluOut;
	wordT adderOut;
	wordT addr1;
	wordT addr2;
	wordT aluB;
	wordT pcNext;
	wordT sr1Data;
	wordT sr2Data;
	regIdxT drIdx;
	regIdxT sr1Idx;
	logic benNext;
	logic busLoad;

	assign opcode = opcodeT'(ir[15:12]);

	assign drIdx = ctrl.drSel ? 3'd7 : ir[11:9];
	assign sr1Idx = ctrl.sr1Sel ? ir[8:6] : ir[11:9];

	regFile regFile_i (
		.Clk(Clk),
		.arstN(arstN),
		.we(ctrl.ldReg),
		.dr(drIdx),
		.din(bus),
		.sr1(sr1Idx),
		.sr2(ir[2:0]),
		.sr1Data(sr1Data),
		.sr2Data(sr2Data)
	);

	// IR[5] selects the imm5 form of ADD and AND
	assign aluB = (ctrl.sr2Imm && ir[5]) ? {{11{ir[4]}}, ir[4:0]} : sr2Data;

	always_comb
	begin
		unique case (ctrl.aluOp)
			aluAdd: aluOut = sr1Data + aluB;
			aluAnd: aluOut = sr1Data & aluB;
			aluNot: aluOut = ~sr1Data;
			default: aluOut = sr1Data;
		endcase
	end

	// Address adder
	assign addr1 = (ctrl.addr1Sel == addr1Base) ? sr1Data : pc;

	always_comb
	begin
		unique case (ctrl.addr2Sel)
			addr2Off6: addr2 = {{10{ir[5]}}, ir[5:0]};
			addr2Off9: addr2 = {{7{ir[8]}}, ir[8:0]};
			addr2Off11: addr2 = {{5{ir[10]}}, ir[10:0]};
			default: addr2 = '0;
		endcase
	end

	assign adderOut = addr1 + addr2;

	always_comb
	begin
		unique case (ctrl.gate)
			busPc: bus = pc;
			busMdr: bus = mdr;
			busAlu: bus = aluOut;
			busMarmux: bus = adderOut;
			default: bus = '0;
		endcase
	end

	always_comb
	begin
		unique case (ctrl.pcSel)
			pcBus: pcNext = bus;
			pcAdder: pcNext = adderOut;
			default: pcNext = pc + 16'd1;
		endcase
	end

	// Branch enable from the nzp mask in IR[11:9]
	assign benNext = (ir[11] & cc.n) | (ir[10] & cc.z) | (ir[9] & cc.p);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= resetPc;
			ir <= '0;
			cc <= '0;
			ben <= 1'b0;
			led <= '0;
		end
		else
		begin
			if (ctrl.ldPc)
				pc <= pcNext;
			if (ctrl.ldIr)
				ir <= bus;
			if (ctrl.ldCc)
			begin
				cc.n <= bus[15];
				cc.z <= (bus == '0);
				cc.p <= !bus[15] && (bus != '0);
			end
			if (ctrl.ldBen)
				ben <= benNext;
			if (ctrl.ldLed)
				led <= ir[11:0];
		end
	end

	always_ff @(posedge Clk)
	begin
		if (ctrl.ldMar)
			mar <= bus;
		if (ctrl.ldMdr)
			mdr <= ctrl.mioEn ? memRdata : bus;
	end

	// Any register that takes the bus needs a driver on it
	assign busLoad = ctrl.ldMar || ctrl.ldIr || ctrl.ldReg || ctrl.ldCc
		|| (ctrl.ldPc && ctrl.pcSel == pcBus) || (ctrl.ldMdr && !ctrl.mioEn);

	busDriven: assert property (@(posedge Clk) disable iff (!arstN)
		busLoad |-> ctrl.gate != busNone);

endmodule

/* datapath/regFile.sv */
module regFile
	import lc3Pkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic we,
	input regIdxT dr,
	input wordT din,
	input regIdxT sr1,
	input regIdxT sr2,
	output wordT sr1Data,
	output wordT sr2Data
);

	wordT regs [8];

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[dr] <= din;
		end
	end

	// Combinational read ports
	assign sr1Data = regs[sr1];
	assign sr2Data = regs[sr2];

endmodule

/* files.f */
common/lc3Pkg.sv
common/ctrlPkg.sv
datapath/regFile.sv
datapath/datapath.sv
verilog/controlUnit.sv
verilog/lc3Core.sv
verif/coreChecker.sv
verif/tbTop.sv

/* verif/coreChecker.sv */
module coreChecker
	import lc3Pkg::*, ctrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input memReqT memReq,
	input logic memReqValid,
	input logic memReqReady,
	input logic halted,
	input logic [11:0] led,
	input logic [63:0] testName,
	input wordT expAddr [6],
	input wordT expData [6],
	input int expCount,
	input logic [11:0] expLed,
	input logic report,
	output int valueErrs,
	output int otherErrs
);

	timeunit 1ns;
	timeprecision 1ps;

	int storeIdx = 0;
	logic haltSeen = 1'b0;
	logic reqSeen = 1'b0;

	initial
	begin
		valueErrs = 0;
		otherErrs = 0;
	end

	// Sampled mid-cycle where DUT outputs and driven inputs are settled
	always @(negedge Clk)
	begin
		if (!arstN)
		begin
			storeIdx = 0;
			haltSeen = 1'b0;
			reqSeen = 1'b0;
			if (halted || led != '0)
			begin
				otherErrs++;
				$display("Test %0s: core shows halted or a lit LED while in reset", testName);
			end
		end
		else
		begin
			// First request after reset is the fetch at 16'h3000
			if (memReqValid && !reqSeen)
			begin
				reqSeen = 1'b1;
				if (memReq.we || memReq.addr != 16'h3000)
				begin
					valueErrs++;
					$display("ERROR %0s first request: expected read of %h, got addr %h we %b",
						testName, 16'h3000, memReq.addr, memReq.we);
				end
			end
			if (halted && memReqValid)
			begin
				otherErrs++;
				$display("Test %0s: core issued a memory request after it halted", testName);
			end
			if (memReqValid && memReqReady && memReq.we)
			begin
				if (storeIdx >= expCount)
				begin
					otherErrs++;
					$display("Test %0s: unexpected extra store of %h to %h",
						testName, memReq.wdata, memReq.addr);
				end
				else
				begin
					if (memReq.addr != expAddr[storeIdx])
					begin
						valueErrs++;
						$display("ERROR %0s store %0d address: expected %h, actual %h",
							testName, storeIdx, expAddr[storeIdx], memReq.addr);
					end
					if (memReq.wdata != expData[storeIdx])
					begin
						valueErrs++;
						$display("ERROR %0s store %0d data: expected %h, actual %h",
							testName, storeIdx, expData[storeIdx], memReq.wdata);
					end
				end
				storeIdx++;
			end
			if (halted && !haltSeen)
			begin
				haltSeen = 1'b1;
				if (storeIdx < expCount)
				begin
					otherErrs++;
					$display("Test %0s: core halted after %0d of %0d expected stores",
						testName, storeIdx, expCount);
				end
				if (led != expLed)
				begin
					valueErrs++;
					$display("ERROR %0s led: expected %h, actual %h", testName, expLed, led);
				end
			end
		end
	end

	always @(posedge report)
		$display("Checks done: %0d value errors, %0d other errors", valueErrs, otherErrs);

endmodule

/* verif/tbTop.sv */
module tbTop;

	import lc3Pkg::*;
	import ctrlPkg::*;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numRows = 4;
	localparam int timeoutCycles = numRows * 400;

	logic Clk;
	logic arstN;
	memReqT memReq;
	logic memReqValid;
	logic memReqReady;
	memRspT memRsp;
	logic memRspValid;
	logic [11:0] led;
	logic halted;

	logic report;
	int valueErrs;
	int otherErrs;
	int seed;
	logic [31:0] rnd;
	wordT mem [65536];

	// Request accepted at the coming edge
	logic fire;
	memReqT fireReq;
	logic rspWait;
	wordT rspData;

	// Current row as seen by the checker
	logic [63:0] curName;
	wordT curAddr [6];
	wordT curData [6];
	int curCount;
	logic [11:0] curLed;

	// Programs start at resetPc and data words at 16'h3020
	logic [63:0] nameTab [numRows] = '{"alu", "load", "branch", "jump"};
	wordT progTab [numRows][16] = '{
		'{16'h5020, 16'h1227, 16'h147D, 16'h1642, 16'h58C1, 16'h9AFF, 16'h5D78, 16'h3618,
			16'h3818, 16'h3A18, 16'h3C18, 16'h3418, 16'hDABC, 16'h0000, 16'h0000, 16'h0000},
		'{16'h221F, 16'hE41E, 16'h6681, 16'h6882, 16'hEA2B, 16'h7340, 16'h7741, 16'h7942,
			16'h7543, 16'h6D7F, 16'h7D44, 16'hD123, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h5260, 16'h0A01, 16'h1021, 16'h127E, 16'h0C01, 16'h1022, 16'h1465, 16'h0401,
			16'h1024, 16'h0201, 16'h1028, 16'h56E0, 16'h0401, 16'h1030, 16'h3011, 16'hD5A5},
		'{16'hE807, 16'hC100, 16'hDBAD, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
			16'h0001, 16'h1029, 16'h923F, 16'h0E01, 16'hDBAD, 16'h3212, 16'h3012, 16'hD0F0}
	};
	wordT dataTab [numRows][4] = '{
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h1234, 16'h8001, 16'h00FF, 16'h0000},
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};
	wordT expAddrTab [numRows][6] = '{
		'{16'h3020, 16'h3021, 16'h3022, 16'h3023, 16'h3024, 16'h0000},
		'{16'h3030, 16'h3031, 16'h3032, 16'h3033, 16'h3034, 16'h0000},
		'{16'h3020, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h3020, 16'h3021, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};
	// 16'h6A75 is the fill word at 16'h302F
	wordT expDataTab [numRows][6] = '{
		'{16'h000B, 16'h0003, 16'hFFF4, 16'hFFF0, 16'h0004, 16'h0000},
		'{16'h1234, 16'h8001, 16'h00FF, 16'h3020, 16'h6A75, 16'h0000},
		'{16'h0005, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'hFFF6, 16'h0009, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};
	int expCountTab [numRows] = '{5, 5, 1, 2};
	logic [11:0] expLedTab [numRows] = '{12'hABC, 12'h123, 12'h5A5, 12'h0F0};

	lc3Core lc3Core_i (
		.Clk(Clk),
		.arstN(arstN),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.memRsp(memRsp),
		.memRspValid(memRspValid),
		.led(led),
		.halted(halted)
	);

	coreChecker coreChecker_i (
		.Clk(Clk),
		.arstN(arstN),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.halted(halted),
		.led(led),
		.testName(curName),
		.expAddr(curAddr),
		.expData(curData),
		.expCount(curCount),
		.expLed(curLed),
		.report(report),
		.valueErrs(valueErrs),
		.otherErrs(otherErrs)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	// Memory model samples the handshake mid-cycle
	always @(negedge Clk)
	begin
		fire = arstN && memReqValid && memReqReady;
		fireReq = memReq;
	end

	always @(posedge Clk)
	begin
		#1;
		memRspValid = 1'b0;
		if (!arstN)
			rspWait = 1'b0;
		else
		begin
			// Read data shows up two cycles after acceptance
			if (rspWait)
			begin
				memRspValid = 1'b1;
				memRsp.rdata = rspData;
				rspWait = 1'b0;
			end
			if (fire && fireReq.we)
				mem[fireReq.addr] = fireReq.wdata;
			else if (fire)
			begin
				rspData = mem[fireReq.addr];
				rspWait = 1'b1;
			end
		end
		rnd = $random(seed);
		memReqReady = rnd[0];
	end

	task automatic loadMemory(input int row);
		for (int a = 0; a < 65536; a++)
			mem[a] = 16'(a) ^ 16'h5A5A;
		for (int i = 0; i < 16; i++)
			mem[resetPc + 16'(i)] = progTab[row][i];
		for (int i = 0; i < 4; i++)
			mem[16'h3020 + 16'(i)] = dataTab[row][i];
	endtask

	task automatic selectRow(input int row);
		curName = nameTab[row];
		for (int i = 0; i < 6; i++)
		begin
			curAddr[i] = expAddrTab[row][i];
			curData[i] = expDataTab[row][i];
		end
		curCount = expCountTab[row];
		curLed = expLedTab[row];
	endtask

	initial
	begin
		seed = 32'hc589;
		arstN = 1'b0;
		memReqReady = 1'b0;
		memRsp = '0;
		memRspValid = 1'b0;
		rspWait = 1'b0;
		fire = 1'b0;
		report = 1'b0;
		selectRow(0);
		for (int row = 0; row < numRows; row++)
		begin
			@(posedge Clk);
			#1 arstN = 1'b0;
			selectRow(row);
			loadMemory(row);
			repeat (5) @(posedge Clk);
			#1 arstN = 1'b1;
			while (!halted)
				@(negedge Clk);
			// Some idle cycles to catch requests after the halt
			repeat (10) @(posedge Clk);
		end
		report = 1'b1;
		#1;
		if (valueErrs + otherErrs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		repeat (timeoutCycles) @(posedge Clk);
		$display("Timeout: the core never halted within %0d cycles", timeoutCycles);
		$display("sim failed");
		$finish;
	end

endmodule

/* verilog/controlUnit.sv */
module controlUnit
	import lc3Pkg::*, ctrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input opcodeT opcode,
	input logic ben,
	output ctrlWordT ctrl,
	output logic memReqValid,
	output logic memWe,
	input logic memReqReady,
	input logic memRspValid,
	output logic halted
);

	typedef enum logic [3:0] {
		sFetch,
		sFetchReq,
		sFetchWait,
		sLoadIr,
		sDecode,
		sAlu,
		sLea,
		sBr,
		sJmp,
		sMemAddr,
		sLdReq,
		sLdWait,
		sLoadReg,
		sStMdr,
		sStReq,
		sHalt
	} stateT;

	stateT state;
	stateT stateNext;
	logic baseAddr;

	// LDR, STR and JMP address off the base register in IR[8:6]
	assign baseAddr = (opcode == opLdr) || (opcode == opStr) || (opcode == opJmp);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			state <= sFetch;
		else
			state <= stateNext;
	end

	always_comb
	begin
		stateNext = state;
		ctrl = '0;
		unique case (state)
			sFetch:
			begin
				ctrl.gate = busPc;
				ctrl.ldMar = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcSel = pcInc;
				stateNext = sFetchReq;
			end
			sFetchReq:
				if (memReqReady)
					stateNext = sFetchWait;
			sFetchWait:
			begin
				ctrl.mioEn = 1'b1;
				ctrl.ldMdr = memRspValid;
				if (memRspValid)
					stateNext = sLoadIr;
			end
			sLoadIr:
			begin
				ctrl.gate = busMdr;
				ctrl.ldIr = 1'b1;
				stateNext = sDecode;
			end
			sDecode:
			begin
				ctrl.ldBen = 1'b1;
				case (opcode)
					opAdd, opAnd, opNot: stateNext = sAlu;
					opLd, opLdr, opSt, opStr: stateNext = sMemAddr;
					opBr: stateNext = sBr;
					opJmp: stateNext = sJmp;
					opLea: stateNext = sLea;
					default: stateNext = sHalt;
				endcase
				// PAUSE and unknown opcodes latch the LED on the way to halt
				if (stateNext == sHalt)
					ctrl.ldLed = 1'b1;
			end
			sAlu:
			begin
				ctrl.gate = busAlu;
				ctrl.sr1Sel = 1'b1;
				ctrl.sr2Imm = 1'b1;
				ctrl.aluOp = (opcode == opAdd) ? aluAdd : (opcode == opAnd) ? aluAnd : aluNot;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				stateNext = sFetch;
			end
			sLea:
			begin
				ctrl.gate = busMarmux;
				ctrl.addr1Sel = addr1Pc;
				ctrl.addr2Sel = addr2Off9;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				stateNext = sFetch;
			end
			sBr:
			begin
				ctrl.addr1Sel = addr1Pc;
				ctrl.addr2Sel = addr2Off9;
				ctrl.pcSel = pcAdder;
				ctrl.ldPc = ben;
				stateNext = sFetch;
			end
			sJmp:
			begin
				ctrl.sr1Sel = 1'b1;
				ctrl.addr1Sel = addr1Base;
				ctrl.addr2Sel = addr2Zero;
				ctrl.pcSel = pcAdder;
				ctrl.ldPc = 1'b1;
				stateNext = sFetch;
			end
			sMemAddr:
			begin
				ctrl.gate = busMarmux;
				ctrl.sr1Sel = baseAddr;
				ctrl.addr1Sel = baseAddr ? addr1Base : addr1Pc;
				ctrl.addr2Sel = baseAddr ? addr2Off6 : addr2Off9;
				ctrl.ldMar = 1'b1;
				if (opcode == opLd || opcode == opLdr)
					stateNext = sLdReq;
				else
					stateNext = sStMdr;
			end
			sLdReq:
				if (memReqReady)
					stateNext = sLdWait;
			sLdWait:
			begin
				ctrl.mioEn = 1'b1;
				ctrl.ldMdr = memRspValid;
				if (memRspValid)
					stateNext = sLoadReg;
			end
			sLoadReg:
			begin
				ctrl.gate = busMdr;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				stateNext = sFetch;
			end
			sStMdr:
			begin
				// Source register in IR[11:9] passes through the ALU
				ctrl.gate = busAlu;
				ctrl.aluOp = aluPass;
				ctrl.ldMdr = 1'b1;
				stateNext = sStReq;
			end
			sStReq:
				if (memReqReady)
					stateNext = sFetch;
			default:
				stateNext = sHalt;
		endcase
	end

	assign memReqValid = (state == sFetchReq) || (state == sLdReq) || (state == sStReq);
	assign memWe = (state == sStReq);
	assign halted = (state == sHalt);

	reqHeld: assert property (@(posedge Clk) disable iff (!arstN)
		memReqValid && !memReqReady |=> memReqValid && $stable(memWe) && $stable(state));

	rspInWait: assert property (@(posedge Clk) disable iff (!arstN)
		memRspValid |-> state inside {sFetchWait, sLdWait});

endmodule

/* verilog/lc3Core.sv */
module lc3Core
	import lc3Pkg::*, ctrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	output memReqT memReq,
	output logic memReqValid,
	input logic memReqReady,
	input memRspT memRsp,
	input logic memRspValid,
	output logic [11:0] led,
	output logic halted
);

	ctrlWordT ctrl;
	opcodeT opcode;
	logic ben;
	logic memWe;
	wordT mar;
	wordT mdr;

	controlUnit controlUnit_i (
		.Clk(Clk),
		.arstN(arstN),
		.opcode(opcode),
		.ben(ben),
		.ctrl(ctrl),
		.memReqValid(memReqValid),
		.memWe(memWe),
		.memReqReady(memReqReady),
		.memRspValid(memRspValid),
		.halted(halted)
	);

	datapath datapath_i (
		.Clk(Clk),
		.arstN(arstN),
		.ctrl(ctrl),
		.memRdata(memRsp.rdata),
		.opcode(opcode),
		.ben(ben),
		.mar(mar),
		.mdr(mdr),
		.led(led)
	);

	// Address from MAR, store data from MDR
	assign memReq = '{addr: mar, wdata: mdr, we: memWe};

endmodule
